/* hdl/fp_add_pkg.sv */
// binary32 add/subtract shared definitions
// field widths, the two-view word type, flag bit positions and the quiet NaN

`default_nettype none

package fp_add_pkg;

    ////////////////////
    // field widths
    localparam int EXPO_WIDTH = 8;
    localparam int FRAC_WIDTH = 23;
    // significand including the hidden bit
    localparam int SIG_WIDTH  = 24;
    // guard, round and sticky
    localparam int GRS_WIDTH  = 3;
    localparam int EXPO_BIAS  = 127;

    ////////////////////
    // word views
    typedef struct packed {
        logic                  sign;
        logic [EXPO_WIDTH-1:0] expo;
        logic [FRAC_WIDTH-1:0] frac;
    } fp32_fields_t;

    // same 32 bits, read either raw or as fields
    typedef union packed {
        logic [31:0]  bits;
        fp32_fields_t f;
    } fp32_word_t;

    // quiet NaN with only the top fraction bit set
    localparam logic [31:0] CANONICAL_NAN = 32'h7fc0_0000;

    ////////////////////
    // flag positions in the 3-bit flags word
    localparam int FLAG_INVALID  = 2;
    localparam int FLAG_OVERFLOW = 1;
    localparam int FLAG_INEXACT  = 0;

endpackage

`default_nettype wire

/* hdl/fp_unpack_stage.sv */
// fp add unpack stage
// classifies both operands, applies the op bit, flushes subnormals,
// orders by magnitude and registers the exponent difference

`timescale 1ns/1ns
`default_nettype none

module fp_unpack_stage
    import fp_add_pkg::*;
#(
    parameter int ID_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  fp32_word_t            in_a,
    input  fp32_word_t            in_b,
    input  logic                  in_sub,
    input  logic [ID_WIDTH-1:0]   in_tag,
    output logic                  u_valid,
    input  logic                  u_ready,
    output logic                  u_big_sign,
    output logic [EXPO_WIDTH-1:0] u_big_expo,
    output logic [SIG_WIDTH-1:0]  u_big_sig,
    output logic [SIG_WIDTH-1:0]  u_small_sig,
    output logic [EXPO_WIDTH-1:0] u_expo_diff,
    output logic                  u_subtract,
    output logic                  u_special,
    output logic [31:0]           u_special_word,
    output logic                  u_invalid,
    output logic [ID_WIDTH-1:0]   u_tag
);

    logic                  a_max, b_max, a_zero, b_zero;
    logic                  a_nan, b_nan, a_snan, b_snan, a_inf, b_inf;
    logic                  b_sign_eff, sub_eff, swap, inf_sign, invalid;
    logic [SIG_WIDTH-1:0]  a_sig, b_sig;
    logic [30:0]           a_mag, b_mag;
    logic [EXPO_WIDTH-1:0] small_expo, small_expo_q;

    ////////////////////
    // classify
    assign a_max  = in_a.f.expo == '1;
    assign b_max  = in_b.f.expo == '1;
    assign a_zero = in_a.f.expo == '0;
    assign b_zero = in_b.f.expo == '0;
    assign a_nan  = a_max & (|in_a.f.frac);
    assign b_nan  = b_max & (|in_b.f.frac);
    // quiet bit clear means signaling
    assign a_snan = a_nan & ~in_a.f.frac[FRAC_WIDTH-1];
    assign b_snan = b_nan & ~in_b.f.frac[FRAC_WIDTH-1];
    assign a_inf  = a_max & ~(|in_a.f.frac);
    assign b_inf  = b_max & ~(|in_b.f.frac);

    assign b_sign_eff = in_b.f.sign ^ in_sub;
    assign sub_eff    = in_a.f.sign ^ b_sign_eff;

    // subnormals read as zero, so the fraction drops out too
    assign a_sig = a_zero ? '0 : {1'b1, in_a.f.frac};
    assign b_sig = b_zero ? '0 : {1'b1, in_b.f.frac};
    assign a_mag = {in_a.f.expo, a_sig[FRAC_WIDTH-1:0]};
    assign b_mag = {in_b.f.expo, b_sig[FRAC_WIDTH-1:0]};
    assign swap  = b_mag > a_mag;

    assign small_expo = swap ? in_a.f.expo : in_b.f.expo;
    assign inf_sign   = a_inf ? in_a.f.sign : b_sign_eff;
    assign invalid    = a_snan | b_snan | (a_inf & b_inf & sub_eff);

    ////////////////////
    // stage register
    assign in_ready = ~u_valid | u_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            u_valid <= 1'b0;
        end else if (in_ready) begin
            u_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            u_big_sign     <= swap ? b_sign_eff : in_a.f.sign;
            u_big_expo     <= swap ? in_b.f.expo : in_a.f.expo;
            u_big_sig      <= swap ? b_sig : a_sig;
            u_small_sig    <= swap ? a_sig : b_sig;
            u_expo_diff    <= (swap ? in_b.f.expo : in_a.f.expo) - small_expo;
            small_expo_q   <= small_expo;
            u_subtract     <= sub_eff;
            u_special      <= a_nan | b_nan | a_inf | b_inf;
            u_invalid      <= invalid;
            // NaN wins over infinity
            u_special_word <= (a_nan | b_nan | invalid) ? CANONICAL_NAN :
                              {inf_sign, {EXPO_WIDTH{1'b1}}, {FRAC_WIDTH{1'b0}}};
            u_tag          <= in_tag;
        end
    end

    big_expo_order: assert property (@(posedge clk) disable iff (rst)
        u_valid |-> u_big_expo >= small_expo_q);

endmodule

`default_nettype wire

/* hdl/fp_align_add_stage.sv */
// fp add align and add stage
// shifts the smaller significand right with guard, round and sticky,
// then adds or subtracts the magnitudes

`timescale 1ns/1ns
`default_nettype none

module fp_align_add_stage
    import fp_add_pkg::*;
#(
    parameter int ID_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  u_valid,
    output logic                  u_ready,
    input  logic                  u_big_sign,
    input  logic [EXPO_WIDTH-1:0] u_big_expo,
    input  logic [SIG_WIDTH-1:0]  u_big_sig,
    input  logic [SIG_WIDTH-1:0]  u_small_sig,
    input  logic [EXPO_WIDTH-1:0] u_expo_diff,
    input  logic                  u_subtract,
    input  logic                  u_special,
    input  logic [31:0]           u_special_word,
    input  logic                  u_invalid,
    input  logic [ID_WIDTH-1:0]   u_tag,
    output logic                  a_valid,
    input  logic                  a_ready,
    output logic                  a_sign,
    output logic [EXPO_WIDTH-1:0] a_expo,
    output logic [SIG_WIDTH:0]    a_sum,
    output logic [GRS_WIDTH-1:0]  a_grs,
    output logic                  a_special,
    output logic [31:0]           a_special_word,
    output logic                  a_invalid,
    output logic [ID_WIDTH-1:0]   a_tag
);

    // beyond this shift the small operand only feeds sticky
    localparam int MAX_SHIFT = SIG_WIDTH + 2;
    localparam int EXT_WIDTH = SIG_WIDTH + MAX_SHIFT;
    localparam int SUM_WIDTH = SIG_WIDTH + GRS_WIDTH + 1;

    logic [4:0]           shamt;
    logic [EXT_WIDTH-1:0] small_ext;
    logic [SIG_WIDTH-1:0] small_aligned;
    logic                 guard, round_bit, sticky;
    logic [SUM_WIDTH-1:0] big_op, small_op, sum;
    logic                 sum_zero;
    logic                 a_sub_q;

    ////////////////////
    // alignment
    assign shamt = (u_expo_diff > EXPO_WIDTH'(MAX_SHIFT)) ? 5'(MAX_SHIFT) : u_expo_diff[4:0];

    assign small_ext     = {u_small_sig, {MAX_SHIFT{1'b0}}} >> shamt;
    assign small_aligned = small_ext[EXT_WIDTH-1 -: SIG_WIDTH];
    assign guard         = small_ext[MAX_SHIFT-1];
    assign round_bit     = small_ext[MAX_SHIFT-2];
    // everything below round collapses into one bit
    assign sticky        = |small_ext[MAX_SHIFT-3:0];

    ////////////////////
    // magnitude add
    assign big_op   = {1'b0, u_big_sig, {GRS_WIDTH{1'b0}}};
    assign small_op = {1'b0, small_aligned, guard, round_bit, sticky};

    // ordering keeps the difference non-negative
    assign sum      = u_subtract ? big_op - small_op : big_op + small_op;
    assign sum_zero = sum == '0;

    ////////////////////
    // stage register
    assign u_ready = ~a_valid | a_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            a_valid <= 1'b0;
        end else if (u_ready) begin
            a_valid <= u_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (u_ready && u_valid) begin
            // exact cancellation is +0, a plain sum of zeros keeps its sign
            a_sign         <= u_big_sign & ~(u_subtract & sum_zero);
            a_expo         <= u_big_expo;
            a_sum          <= sum[SUM_WIDTH-1:GRS_WIDTH];
            a_grs          <= sum[GRS_WIDTH-1:0];
            a_sub_q        <= u_subtract;
            a_special      <= u_special;
            a_special_word <= u_special_word;
            a_invalid      <= u_invalid;
            a_tag          <= u_tag;
        end
    end

    // a difference of ordered magnitudes never carries out
    no_carry_on_sub: assert property (@(posedge clk) disable iff (rst)
        a_valid |-> !(a_sub_q && a_sum[SIG_WIDTH]));

endmodule

`default_nettype wire

/* hdl/fp_normalize_round_stage.sv */
// fp add normalize, round and pack stage
// leading-zero normalize, round to nearest even, overflow and
// flush-to-zero handling, then packs the result word and flags

`timescale 1ns/1ns
`default_nettype none

module fp_normalize_round_stage
    import fp_add_pkg::*;
#(
    parameter int ID_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  a_valid,
    output logic                  a_ready,
    input  logic                  a_sign,
    input  logic [EXPO_WIDTH-1:0] a_expo,
    input  logic [SIG_WIDTH:0]    a_sum,
    input  logic [GRS_WIDTH-1:0]  a_grs,
    input  logic                  a_special,
    input  logic [31:0]           a_special_word,
    input  logic                  a_invalid,
    input  logic [ID_WIDTH-1:0]   a_tag,
    output logic                  out_valid,
    input  logic                  out_ready,
    output fp32_word_t            out_result,
    output logic [2:0]            out_flags,
    output logic [ID_WIDTH-1:0]   out_tag
);

    localparam int NORM_WIDTH = SIG_WIDTH + GRS_WIDTH;

    logic [NORM_WIDTH-1:0] norm_in, norm_shift;
    logic [4:0]            lzc;
    logic [SIG_WIDTH-1:0]  mant;
    logic                  guard, round_bit, sticky, round_up, inexact;
    logic [SIG_WIDTH:0]    mant_rnd;
    logic signed [9:0]     expo_norm, expo_final;
    logic [FRAC_WIDTH-1:0] frac_final;
    fp32_word_t            result_next;
    logic [2:0]            flags_next;

    assign norm_in = {a_sum[SIG_WIDTH-1:0], a_grs};

    // leading zero count where the highest set bit wins
    always_comb begin
        lzc = 5'(NORM_WIDTH);
        for (int i = 0; i < NORM_WIDTH; i++) begin
            if (norm_in[i]) begin
                lzc = 5'(NORM_WIDTH - 1 - i);
            end
        end
    end

    assign norm_shift = norm_in << lzc;

    ////////////////////
    // normalize
    always_comb begin
        if (a_sum[SIG_WIDTH]) begin
            // carry out shifts one place right and the lost bit joins sticky
            mant      = a_sum[SIG_WIDTH:1];
            guard     = a_sum[0];
            round_bit = a_grs[2];
            sticky    = |a_grs[1:0];
            expo_norm = $signed({2'b00, a_expo}) + 10'sd1;
        end else begin
            mant      = norm_shift[NORM_WIDTH-1 -: SIG_WIDTH];
            guard     = norm_shift[2];
            round_bit = norm_shift[1];
            sticky    = norm_shift[0];
            expo_norm = $signed({2'b00, a_expo}) - $signed({5'b00000, lzc});
        end
    end

    ////////////////////
    // round to nearest with ties to even
    assign round_up   = guard & (round_bit | sticky | mant[0]);
    assign inexact    = guard | round_bit | sticky;
    assign mant_rnd   = {1'b0, mant} + {{SIG_WIDTH{1'b0}}, round_up};
    assign expo_final = expo_norm + $signed({9'b0, mant_rnd[SIG_WIDTH]});
    // a rounding carry leaves the fraction all zero
    assign frac_final = mant_rnd[FRAC_WIDTH-1:0];

    ////////////////////
    // pack
    always_comb begin
        result_next.f.sign = a_sign;
        result_next.f.expo = expo_final[EXPO_WIDTH-1:0];
        result_next.f.frac = frac_final;
        flags_next = 3'b000;
        flags_next[FLAG_INEXACT] = inexact;
        if (a_special) begin
            result_next.bits = a_special_word;
            flags_next = 3'b000;
            flags_next[FLAG_INVALID] = a_invalid;
        end else if (!a_sum[SIG_WIDTH] && norm_in == '0) begin
            // sign already resolved upstream for cancellation
            result_next.f.expo = '0;
            result_next.f.frac = '0;
            flags_next = 3'b000;
        end else if (expo_final >= 10'sd255) begin
            result_next.f.expo = '1;
            result_next.f.frac = '0;
            flags_next[FLAG_OVERFLOW] = 1'b1;
            flags_next[FLAG_INEXACT] = 1'b1;
        end else if (expo_final <= 10'sd0) begin
            // below the smallest normal flush to zero with the big operand sign
            result_next.f.expo = '0;
            result_next.f.frac = '0;
            flags_next[FLAG_INEXACT] = 1'b1;
        end
    end

    ////////////////////
    // output register
    assign a_ready = ~out_valid | out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (a_ready) begin
            out_valid <= a_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (a_ready && a_valid) begin
            out_result <= result_next;
            out_flags  <= flags_next;
            out_tag    <= a_tag;
        end
    end

    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_result)
            && $stable(out_flags) && $stable(out_tag));

endmodule

`default_nettype wire

/* hdl/fp_add_unit.sv */
// binary32 add/subtract unit
// three registered stages joined by valid/ready handshakes

`timescale 1ns/1ns
`default_nettype none

module fp_add_unit
    import fp_add_pkg::*;
#(
    parameter int ID_WIDTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  fp32_word_t          in_a,
    input  fp32_word_t          in_b,
    input  logic                in_sub,
    input  logic [ID_WIDTH-1:0] in_tag,
    output logic                out_valid,
    input  logic                out_ready,
    output fp32_word_t          out_result,
    output logic [2:0]          out_flags,
    output logic [ID_WIDTH-1:0] out_tag
);

    ////////////////////
    // unpack to align/add
    logic                  u_valid, u_ready, u_big_sign, u_subtract, u_special, u_invalid;
    logic [EXPO_WIDTH-1:0] u_big_expo, u_expo_diff;
    logic [SIG_WIDTH-1:0]  u_big_sig, u_small_sig;
    logic [31:0]           u_special_word;
    logic [ID_WIDTH-1:0]   u_tag;

    // align/add to normalize
    logic                  a_valid, a_ready, a_sign, a_special, a_invalid;
    logic [EXPO_WIDTH-1:0] a_expo;
    logic [SIG_WIDTH:0]    a_sum;
    logic [GRS_WIDTH-1:0]  a_grs;
    logic [31:0]           a_special_word;
    logic [ID_WIDTH-1:0]   a_tag;

    fp_unpack_stage #(.ID_WIDTH(ID_WIDTH)) unpack0 (.*);

    fp_align_add_stage #(.ID_WIDTH(ID_WIDTH)) align_add0 (.*);

    fp_normalize_round_stage #(.ID_WIDTH(ID_WIDTH)) normalize0 (.*);

endmodule

`default_nettype wire

/* bench/fp_add_model.svh */
// reference model for the binary32 add/subtract unit
// LCG step and the expected result and flags for one operation

`ifndef FP_ADD_MODEL_SVH
`define FP_ADD_MODEL_SVH

`default_nettype none

// plain LCG step on state the caller keeps
function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

// value of a binary32 word with subnormals read as zero
function automatic real to_real(input logic [31:0] w);
    logic [10:0] e11;
    if (w[30:23] == 8'h00) begin
        return 0.0;
    end
    e11 = 11'(int'(w[30:23]) - EXPO_BIAS + 1023);
    return $bitstoreal({w[31], e11, w[22:0], 29'h0});
endfunction

function automatic void model_add(input logic [31:0] a, input logic [31:0] b,
                                  input logic sub, output logic [31:0] res,
                                  output logic [2:0] flags);
    logic [31:0] bb;
    logic        a_nan, b_nan, a_inf, b_inf, inf_clash, up;
    real         ra, rb, sum, rr;
    logic [63:0] d;
    logic [52:0] m;
    logic [24:0] mant;
    int          e;
    bb        = {b[31] ^ sub, b[30:0]};
    flags     = 3'b000;
    a_nan     = a[30:23] == 8'hff && a[22:0] != 23'h0;
    b_nan     = bb[30:23] == 8'hff && bb[22:0] != 23'h0;
    a_inf     = a[30:23] == 8'hff && a[22:0] == 23'h0;
    b_inf     = bb[30:23] == 8'hff && bb[22:0] == 23'h0;
    inf_clash = a_inf && b_inf && (a[31] != bb[31]);
    if (a_nan || b_nan || inf_clash) begin
        res = CANONICAL_NAN;
        flags[FLAG_INVALID] = (a_nan && !a[22]) || (b_nan && !bb[22]) || inf_clash;
        return;
    end
    if (a_inf || b_inf) begin
        res = {a_inf ? a[31] : bb[31], 8'hff, 23'h0};
        return;
    end
    ra  = to_real(a);
    rb  = to_real(bb);
    // a double sum rounds once more to 24 bits without a double-rounding error
    sum = ra + rb;
    if (sum == 0.0) begin
        res = {a[31] & bb[31], 31'h0};
        return;
    end
    d    = $realtobits(sum);
    e    = int'(d[62:52]) - 1023 + EXPO_BIAS;
    m    = {1'b1, d[51:0]};
    // nearest even on the 29 bits below a 24-bit significand
    up   = m[28] & (m[29] | (|m[27:0]));
    mant = {1'b0, m[52:29]} + 25'(up);
    if (mant[24]) begin
        mant = mant >> 1;
        e    = e + 1;
    end
    if (e >= 255) begin
        res = {d[63], 8'hff, 23'h0};
        flags[FLAG_OVERFLOW] = 1'b1;
        flags[FLAG_INEXACT]  = 1'b1;
    end else if (e <= 0) begin
        res = {d[63], 31'h0};
        flags[FLAG_INEXACT] = 1'b1;
    end else begin
        res = {d[63], 8'(e), mant[22:0]};
        rr  = to_real(res);
        // taking off the larger operand first keeps that difference exact
        if ((ra < 0.0 ? -ra : ra) >= (rb < 0.0 ? -rb : rb)) begin
            flags[FLAG_INEXACT] = (rr - ra - rb) != 0.0;
        end else begin
            flags[FLAG_INEXACT] = (rr - rb - ra) != 0.0;
        end
    end
endfunction

`default_nettype wire

`endif

/* bench/fp_add_tb.sv */
// testbench for the binary32 add/subtract unit
// directed, random and back-pressure runs, checked by concurrent
// assertions against a scoreboard filled from the reference model

`timescale 1ns/1ns
`default_nettype none

module fp_add_tb
    import fp_add_pkg::*;
();

    localparam int ID_WIDTH     = 4;
    localparam int DEPTH        = 16;
    localparam int DIRECTED_OPS = 20;
    localparam int RANDOM_OPS   = 500;
    localparam int BP_OPS       = 200;
    localparam int NUM_OPS      = DIRECTED_OPS + RANDOM_OPS + BP_OPS;

    logic                clk = 1'b0;
    logic                rst, in_valid, in_ready, in_sub, out_valid, out_ready;
    fp32_word_t          in_a, in_b, out_result;
    logic [2:0]          out_flags;
    logic [ID_WIDTH-1:0] in_tag, out_tag;

    // scoreboard ring, oldest pending operation at rd_ptr
    logic [31:0]         exp_result [DEPTH];
    logic [2:0]          exp_flags [DEPTH];
    logic [ID_WIDTH-1:0] exp_tag [DEPTH];
    int                  wr_ptr = 0;
    int                  rd_ptr = 0;
    int                  held, errors = 0, transfers = 0;
    logic [31:0]         head_result;
    logic [2:0]          head_flags;
    logic [ID_WIDTH-1:0] head_tag;
    logic [31:0]         stim_state = 32'h4c25;
    logic [31:0]         bp_state = 32'h4c25;
    logic                bp_on = 1'b0;

    fp_add_unit #(.ID_WIDTH(ID_WIDTH)) dut0 (.*);

    always #10 clk = ~clk;

    assign held        = wr_ptr - rd_ptr;
    assign head_result = exp_result[rd_ptr % DEPTH];
    assign head_flags  = exp_flags[rd_ptr % DEPTH];
    assign head_tag    = exp_tag[rd_ptr % DEPTH];

    always @(posedge clk) begin
        logic [31:0] res;
        logic [2:0]  flg;
        if (!rst && in_valid && in_ready) begin
            model_add(in_a.bits, in_b.bits, in_sub, res, flg);
            exp_result[wr_ptr % DEPTH] <= res;
            exp_flags[wr_ptr % DEPTH]  <= flg;
            exp_tag[wr_ptr % DEPTH]    <= in_tag;
            wr_ptr <= wr_ptr + 1;
        end
        if (!rst && out_valid && out_ready) begin
            rd_ptr    <= rd_ptr + 1;
            transfers <= transfers + 1;
        end
    end

    // consumer stalls on random cycles while back-pressure is on
    always @(negedge clk) begin
        if (bp_on) begin
            bp_state  = lcg_step(bp_state);
            out_ready = bp_state[30];
        end else begin
            out_ready = 1'b1;
        end
    end

    ////////////////////
    // output checks
    output_pending: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready |-> held > 0)
        else begin
            $display("output transfer arrived with no operation pending");
            errors++;
        end

    result_match: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready && held > 0 |-> out_result.bits == head_result)
        else begin
            $display("mismatch out_result expected %h got %h",
                     $sampled(head_result), $sampled(out_result));
            errors++;
        end

    flags_match: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready && held > 0 |-> out_flags == head_flags)
        else begin
            $display("mismatch out_flags expected %h got %h",
                     $sampled(head_flags), $sampled(out_flags));
            errors++;
        end

    tag_match: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready && held > 0 |-> out_tag == head_tag)
        else begin
            $display("mismatch out_tag expected %h got %h",
                     $sampled(head_tag), $sampled(out_tag));
            errors++;
        end

    // the pipeline holds three before it refuses input
    in_ready_full: assert property (@(posedge clk) disable iff (rst)
        !in_ready |-> held == 3)
        else begin
            $display("in_ready fell with %0d operations held", $sampled(held));
            errors++;
        end

    ////////////////////
    // stimulus, called on a falling edge and returns on one
    task automatic send(input logic [31:0] a, input logic [31:0] b, input logic sub);
        int start;
        in_valid = 1'b1;
        in_a     = a;
        in_b     = b;
        in_sub   = sub;
        start    = wr_ptr;
        do begin
            @(negedge clk);
        end while (wr_ptr == start);
        in_tag   = in_tag + 1'b1;
        in_valid = 1'b0;
    endtask

    task automatic send_random();
        logic [31:0] a, b, r;
        stim_state = lcg_step(stim_state);
        a          = stim_state;
        stim_state = lcg_step(stim_state);
        b          = stim_state;
        stim_state = lcg_step(stim_state);
        r          = stim_state;
        // half the operations keep the exponents within a few steps
        if (r[31]) begin
            b[30:23] = a[30:23] + {{5{r[30]}}, r[29:27]};
        end
        send(a, b, r[26]);
    endtask

    task automatic finish_test(input string name, input int start_errors);
        while (held != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        $display("test %s: %0d errors", name, errors - start_errors);
    endtask

    initial begin
        int mark;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_a      = '0;
        in_b      = '0;
        in_sub    = 1'b0;
        in_tag    = '0;
        out_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst  = 1'b0;
        mark = errors;
        @(negedge clk);
        reset_idle: assert (!out_valid && in_ready)
            else begin
                $display("after reset out_valid is not low or in_ready is not high");
                errors++;
            end
        finish_test("reset", mark);

        mark = errors;
        send(32'h3f800000, 32'h40000000, 1'b0);
        // ties, even stays and odd rounds up
        send(32'h3f800000, 32'h33800000, 1'b0);
        send(32'h3f800001, 32'h33800000, 1'b0);
        send(32'h3fffffff, 32'h3fffffff, 1'b0);
        send(32'h3fffffff, 32'h33800000, 1'b0);
        // near cancellation, long left shift
        send(32'h3f800001, 32'h3f800000, 1'b1);
        send(32'h3f800000, 32'h3f7fffff, 1'b1);
        finish_test("normal", mark);

        mark = errors;
        send(32'h7fc00001, 32'h3f800000, 1'b0);
        send(32'h3f800000, 32'hff800001, 1'b0);
        send(32'h7f800000, 32'h7f800000, 1'b1);
        send(32'h7f800000, 32'h40a00000, 1'b1);
        send(32'h3f800000, 32'hff800000, 1'b0);
        send(32'h40490fdb, 32'h40490fdb, 1'b1);
        send(32'hc0490fdb, 32'hc0490fdb, 1'b1);
        finish_test("special", mark);

        mark = errors;
        send(32'h7f7fffff, 32'h7f7fffff, 1'b0);
        send(32'hff7fffff, 32'h7f7fffff, 1'b1);
        send(32'h00000001, 32'h3f800000, 1'b0);
        send(32'h807fffff, 32'h00400000, 1'b1);
        // results just below the smallest normal
        send(32'h00800001, 32'h00800000, 1'b1);
        send(32'h80800001, 32'h80800000, 1'b1);
        finish_test("boundary", mark);

        mark = errors;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            send_random();
        end
        finish_test("random", mark);

        mark  = errors;
        bp_on = 1'b1;
        for (int i = 0; i < BP_OPS; i++) begin
            send_random();
        end
        bp_on = 1'b0;
        finish_test("backpressure", mark);

        $display("%0d transfers checked, %0d errors", transfers, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // 40 cycles per operation, plus room for reset and draining
    initial begin
        #((NUM_OPS * 40 + 200) * 20);
        $display("timeout: the run did not finish in the expected time");
        $display("Done: errors found");
        $finish;
    end

    `include "fp_add_model.svh"

endmodule

`default_nettype wire

/* all.f */
+incdir+bench
hdl/fp_add_pkg.sv
hdl/fp_unpack_stage.sv
hdl/fp_align_add_stage.sv
hdl/fp_normalize_round_stage.sv
hdl/fp_add_unit.sv
bench/fp_add_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the fp add testbench with Verilator, run it, and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module fp_add_tb -f all.f -o fp_add_sim

./obj_dir/fp_add_sim > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
exit 0
